// File: aluUnit.sv
`timescale 1ns/1ns

module aluUnit import cpuPkg::*; (
	input word_t a,
	input word_t b,
	input aluOp_t op,
	output word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	// Branch compare uses SUB
	assign zero = (result == '0);

endmodule

// File: apbMaster.sv
`timescale 1ns/1ns

module apbMaster import cpuPkg::*; (
	input logic CLK,
	input logic rst,
	input logic memStart,
	input logic memWrite,
	input word_t memAddr,
	input word_t memWdata,
	output logic memDone,
	output word_t memRdata,
	output word_t paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output word_t pwdata,
	output logic [3:0] pstrb,
	input word_t prdata,
	input logic pready
);

	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbState_t;

	apbState_t state;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= IDLE;
			pwrite <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (memStart) begin
						state <= SETUP;
						pwrite <= memWrite;
					end
				end
				SETUP: state <= ACCESS;
				ACCESS: begin
					if (pready) begin
						state <= IDLE;
						pwrite <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (memDone && !pwrite)
			memRdata <= prdata; // Load data held for write-back
	end

	assign psel = (state != IDLE);
	assign penable = (state == ACCESS);
	assign memDone = (state == ACCESS) && pready;
	assign paddr = memAddr; // Held in aluOut for the whole transfer
	assign pwdata = memWdata;
	assign pstrb = {4{pwrite}};

endmodule

// File: build.f
cpuPkg.sv
aluUnit.sv
regFile.sv
apbMaster.sv
controlFsm.sv
datapath.sv
cpuTop.sv
tbClock.sv
cpuTb.sv

// File: controlFsm.sv
`timescale 1ns/1ns

module controlFsm import cpuPkg::*; #(
	parameter int COUNT_WIDTH = 32
) (
	input logic CLK,
	input logic rst,
	input opcode_t opcode,
	input logic branchTaken,
	input logic memDone,
	output logic irWrite,
	output logic pcWrite,
	output logic pcCondWrite,
	output logic opWrite,
	output logic aluOutWrite,
	output logic rfWrite,
	output logic memStart,
	output logic memWrite,
	output logic aSel,
	output logic bSel,
	output logic [1:0] wbSel,
	output logic [COUNT_WIDTH-1:0] retired
);

	ctrlState_t state, nextState;

	always_ff @(posedge CLK) begin
		if (rst)
			state <= S_FETCH;
		else
			state <= nextState;
	end

	// Last state of an instruction is the one that returns to fetch
	always_ff @(posedge CLK) begin
		if (rst)
			retired <= '0;
		else if (state != S_FETCH && nextState == S_FETCH)
			retired <= retired + 1'b1;
	end

	always_comb begin
		nextState = state;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		pcCondWrite = 1'b0;
		opWrite = 1'b0;
		aluOutWrite = 1'b0;
		rfWrite = 1'b0;
		memStart = 1'b0;
		memWrite = 1'b0;
		aSel = 1'b0; // pc
		bSel = 1'b0; // Immediate
		wbSel = WBSEL_ALU;
		case (state)
			S_FETCH: begin
				irWrite = 1'b1;
				nextState = S_DECODE;
			end
			S_DECODE: begin
				opWrite = 1'b1;
				aluOutWrite = 1'b1; // Jump or branch target, pc + imm
				case (opcode)
					OP_RTYPE: nextState = S_EXEC_R;
					OP_ITYPE: nextState = S_EXEC_I;
					OP_LOAD, OP_STORE: nextState = S_EXEC_MEM;
					OP_BRANCH: nextState = S_EXEC_BR;
					OP_JAL: nextState = S_EXEC_JAL;
					OP_JALR: nextState = S_EXEC_JALR;
					default: begin
						pcWrite = 1'b1; // Unknown opcode runs as a nop
						nextState = S_FETCH;
					end
				endcase
			end
			S_EXEC_R: begin
				aSel = 1'b1;
				bSel = 1'b1;
				aluOutWrite = 1'b1;
				nextState = S_WB_ALU;
			end
			S_EXEC_I: begin
				aSel = 1'b1;
				aluOutWrite = 1'b1;
				nextState = S_WB_ALU;
			end
			S_EXEC_MEM: begin
				aSel = 1'b1;
				aluOutWrite = 1'b1;
				memStart = 1'b1;
				memWrite = (opcode == OP_STORE);
				nextState = S_MEM;
			end
			S_EXEC_BR: begin
				aSel = 1'b1;
				bSel = 1'b1;
				pcCondWrite = 1'b1;
				pcWrite = ~branchTaken; // Fall through to pc + 4
				nextState = S_FETCH;
			end
			S_EXEC_JAL: begin
				aluOutWrite = 1'b1;
				nextState = S_WB_LINK;
			end
			S_EXEC_JALR: begin
				aSel = 1'b1;
				aluOutWrite = 1'b1;
				nextState = S_WB_LINK;
			end
			S_MEM: begin
				if (memDone) begin
					pcWrite = (opcode == OP_STORE); // Store ends here
					nextState = (opcode == OP_LOAD) ? S_WB_LOAD : S_FETCH;
				end
			end
			S_WB_ALU: begin
				rfWrite = 1'b1;
				pcWrite = 1'b1;
				nextState = S_FETCH;
			end
			S_WB_LOAD: begin
				rfWrite = 1'b1;
				pcWrite = 1'b1;
				wbSel = WBSEL_LOAD;
				nextState = S_FETCH;
			end
			S_WB_LINK: begin
				rfWrite = 1'b1;
				pcWrite = 1'b1;
				wbSel = WBSEL_LINK;
				nextState = S_FETCH;
			end
			default: nextState = S_FETCH;
		endcase
	end

endmodule

// File: cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [6:0] opcode_t;

	localparam opcode_t OP_RTYPE = 7'b0110011;
	localparam opcode_t OP_ITYPE = 7'b0010011;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_JALR = 7'b1100111;

	// Write-back source select
	localparam logic [1:0] WBSEL_ALU = 2'd0;
	localparam logic [1:0] WBSEL_LOAD = 2'd1;
	localparam logic [1:0] WBSEL_LINK = 2'd2;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} aluOp_t;

	typedef enum logic [3:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC_R,
		S_EXEC_I,
		S_EXEC_MEM,
		S_EXEC_BR,
		S_EXEC_JAL,
		S_EXEC_JALR,
		S_MEM,
		S_WB_ALU,
		S_WB_LOAD,
		S_WB_LINK
	} ctrlState_t;

endpackage

// File: cpuTb.sv
`timescale 1ns/1ns

module cpuTb import cpuPkg::*; ();

	localparam word_t RESET_PC = '0;
	localparam int COUNT_WIDTH = 32;

	logic CLK;
	logic rst = 1'b1;
	word_t instrAddr, instrData;
	word_t paddr, pwdata, prdata;
	logic psel, penable, pwrite;
	logic [3:0] pstrb;
	logic pready = 1'b0;
	logic [COUNT_WIDTH-1:0] retired;

	word_t golden [256]; // Header, program, data, store pairs
	word_t dataMem [64];
	int progLen, dataSize, storeCount, cycleLimit;
	int storeIdx = 0;
	int cycles = 0;
	logic [COUNT_WIDTH-1:0] finalRetired;
	logic [7:0] storeBase;
	word_t lastAddr, holdAddr, holdData;
	logic holdWrite;
	logic storeOp;
	logic prevSetup = 1'b0;
	logic prevAccess = 1'b0;
	logic prevReady = 1'b0;
	logic [1:0] waitLeft = 2'd0;
	logic [31:0] rnd;
	integer seed = 73026;

	tbClock #(.PERIOD(10)) clockGen (.CLK(CLK));

	cpuTop #(.RESET_PC(RESET_PC), .COUNT_WIDTH(COUNT_WIDTH)) dut (
		.CLK(CLK), .rst(rst), .instrAddr(instrAddr), .instrData(instrData),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
		.retired(retired)
	);

	// Program words start right after the 4 header words
	assign instrData = golden[8'd4 + {2'b00, instrAddr[7:2]}];
	assign prdata = dataMem[paddr[7:2]];

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t expected);
		if (got !== expected)
			abortRun($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, expected));
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		if (got !== expected)
			abortRun($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, expected));
	endtask

	task automatic checkCount(input string name, input logic [COUNT_WIDTH-1:0] got,
			input logic [COUNT_WIDTH-1:0] expected);
		if (got !== expected)
			abortRun($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, expected));
	endtask

	initial begin
		$readmemh("program_golden.mem", golden);
		progLen = golden[0];
		dataSize = golden[1];
		storeCount = golden[2];
		finalRetired = golden[3];
		if (progLen < 1 || progLen > 64 || dataSize > 64 || 4 + progLen + dataSize + 2 * storeCount > 256)
			abortRun("golden file header is out of range");
		for (int i = 0; i < 64; i++)
			dataMem[6'(i)] = (i < dataSize) ? golden[8'(4 + progLen + i)] : '0;
		storeBase = 8'(4 + progLen + dataSize);
		lastAddr = word_t'((progLen - 1) * 4); // Final self-jump
		cycleLimit = progLen * 4 + storeCount * 8 + 200;
		repeat (7) @(posedge CLK);
		@(negedge CLK);
		checkBit("psel", psel, 1'b0);
		checkBit("penable", penable, 1'b0);
		checkBit("pwrite", pwrite, 1'b0);
		checkWord("instrAddr", instrAddr, RESET_PC);
		@(posedge CLK);
		#1 rst = 1'b0;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit)
			abortRun("timeout: program did not finish");
	end

	// APB slave, 0 to 3 wait states per transfer
	always @(posedge CLK) begin
		#1;
		if (psel && !penable) begin
			rnd = $random(seed);
			waitLeft = rnd[1:0];
			pready = 1'b0;
		end else if (psel && penable) begin
			pready = (waitLeft == 2'd0);
			if (waitLeft != 2'd0)
				waitLeft = waitLeft - 2'd1;
		end else begin
			pready = 1'b0;
		end
	end

	always @(negedge CLK) begin
		if (!rst) begin
			storeOp = (instrData[6:0] == OP_STORE); // pc holds through the transfer
			if (penable && !psel)
				abortRun("penable was high without psel");
			if (prevAccess && !prevReady && !(psel && penable))
				abortRun("APB transfer was dropped before pready");
			if (psel && !penable) begin
				if (prevSetup)
					abortRun("APB setup phase lasted more than one cycle");
				checkBit("pwrite", pwrite, storeOp);
				holdAddr = paddr;
				holdWrite = pwrite;
				holdData = pwdata;
			end
			if (psel && penable) begin
				if (!prevSetup && !(prevAccess && !prevReady))
					abortRun("APB access phase came without a setup cycle");
				checkWord("paddr", paddr, holdAddr);
				checkBit("pwrite", pwrite, holdWrite);
				checkWord("pstrb", {28'b0, pstrb}, storeOp ? 32'hF : 32'h0);
				if (pwrite)
					checkWord("pwdata", pwdata, holdData);
				if (pready) begin // Completes on the next edge
					if (paddr[31:2] >= 30'(dataSize))
						abortRun("APB address is outside the data memory");
					if (pwrite) begin
						if (storeIdx >= storeCount)
							abortRun("a store came after the last expected store");
						checkWord("paddr", paddr, golden[storeBase + 8'(2 * storeIdx)]);
						checkWord("pwdata", pwdata, golden[storeBase + 8'(2 * storeIdx + 1)]);
						dataMem[paddr[7:2]] = pwdata;
						storeIdx = storeIdx + 1;
					end
				end
			end
			prevSetup = psel && !penable;
			prevAccess = psel && penable;
			prevReady = pready;
			if (instrAddr == lastAddr) begin
				if (storeIdx != storeCount) begin
					abortRun("program reached its final jump before all expected stores");
				end else begin
					checkCount("retired", retired, finalRetired);
					$display("Verification passed");
					$finish;
				end
			end
		end
	end

endmodule

// File: cpuTop.sv
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; #(
	parameter word_t RESET_PC = '0,
	parameter int COUNT_WIDTH = 32
) (
	input logic CLK,
	input logic rst,
	output word_t instrAddr,
	input word_t instrData,
	output word_t paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output word_t pwdata,
	output logic [3:0] pstrb,
	input word_t prdata,
	input logic pready,
	output logic [COUNT_WIDTH-1:0] retired
);

	opcode_t opcode;
	logic branchTaken, memDone;
	logic irWrite, pcWrite, pcCondWrite, opWrite, aluOutWrite, rfWrite;
	logic memStart, memWrite, aSel, bSel;
	logic [1:0] wbSel;
	word_t aluA, aluB, aluResult;
	aluOp_t aluOp;
	logic aluZero;
	regIdx_t rfRaddr1, rfRaddr2, rfWaddr;
	word_t rfRdata1, rfRdata2, rfWdata;
	word_t memAddr, memWdata, memRdata;

	controlFsm #(.COUNT_WIDTH(COUNT_WIDTH)) control (
		.CLK(CLK), .rst(rst), .opcode(opcode), .branchTaken(branchTaken),
		.memDone(memDone), .irWrite(irWrite), .pcWrite(pcWrite),
		.pcCondWrite(pcCondWrite), .opWrite(opWrite), .aluOutWrite(aluOutWrite),
		.rfWrite(rfWrite), .memStart(memStart), .memWrite(memWrite), .aSel(aSel),
		.bSel(bSel), .wbSel(wbSel), .retired(retired)
	);

	datapath #(.RESET_PC(RESET_PC)) dp (
		.CLK(CLK), .rst(rst), .irWrite(irWrite), .pcWrite(pcWrite),
		.pcCondWrite(pcCondWrite), .opWrite(opWrite), .aluOutWrite(aluOutWrite),
		.wbSel(wbSel), .aSel(aSel), .bSel(bSel), .instrAddr(instrAddr),
		.instrData(instrData), .opcode(opcode), .branchTaken(branchTaken),
		.aluA(aluA), .aluB(aluB), .aluOp(aluOp), .aluResult(aluResult),
		.aluZero(aluZero), .rfRaddr1(rfRaddr1), .rfRaddr2(rfRaddr2),
		.rfWaddr(rfWaddr), .rfRdata1(rfRdata1), .rfRdata2(rfRdata2),
		.rfWdata(rfWdata), .memAddr(memAddr), .memWdata(memWdata),
		.memRdata(memRdata)
	);

	aluUnit alu (
		.a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero)
	);

	regFile rf (
		.CLK(CLK), .raddr1(rfRaddr1), .raddr2(rfRaddr2), .waddr(rfWaddr),
		.wdata(rfWdata), .we(rfWrite), .rdata1(rfRdata1), .rdata2(rfRdata2)
	);

	apbMaster apb (
		.CLK(CLK), .rst(rst), .memStart(memStart), .memWrite(memWrite),
		.memAddr(memAddr), .memWdata(memWdata), .memDone(memDone),
		.memRdata(memRdata), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
		.pready(pready)
	);

endmodule

// File: datapath.sv
`timescale 1ns/1ns

module datapath import cpuPkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic CLK,
	input logic rst,
	input logic irWrite,
	input logic pcWrite,
	input logic pcCondWrite,
	input logic opWrite,
	input logic aluOutWrite,
	input logic [1:0] wbSel,
	input logic aSel,
	input logic bSel,
	output word_t instrAddr,
	input word_t instrData,
	output opcode_t opcode,
	output logic branchTaken,
	output word_t aluA,
	output word_t aluB,
	output aluOp_t aluOp,
	input word_t aluResult,
	input logic aluZero,
	output regIdx_t rfRaddr1,
	output regIdx_t rfRaddr2,
	output regIdx_t rfWaddr,
	input word_t rfRdata1,
	input word_t rfRdata2,
	output word_t rfWdata,
	output word_t memAddr,
	output word_t memWdata,
	input word_t memRdata
);

	word_t pc, ir, regA, regB, aluOut;
	word_t imm, pcPlus4, jumpTarget;
	logic [2:0] funct3;

	always_ff @(posedge CLK) begin
		if (rst)
			pc <= RESET_PC;
		else if (pcCondWrite && branchTaken)
			pc <= jumpTarget;
		else if (pcWrite)
			pc <= (opcode == OP_JAL || opcode == OP_JALR) ? jumpTarget : pcPlus4;
	end

	always_ff @(posedge CLK) begin
		if (irWrite)
			ir <= instrData;
		if (opWrite) begin
			regA <= rfRdata1;
			regB <= rfRdata2;
		end
		if (aluOutWrite)
			aluOut <= aluResult;
	end

	assign instrAddr = pc;
	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign pcPlus4 = pc + 32'd4;
	assign jumpTarget = {aluOut[31:1], 1'b0}; // jalr clears bit 0

	// Immediate format follows the opcode
	always_comb begin
		case (opcode)
			OP_STORE: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			OP_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			OP_JAL: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default: imm = {{20{ir[31]}}, ir[31:20]};
		endcase
	end

	// pc operand means an address add
	always_comb begin
		aluOp = ALU_ADD;
		if (aSel) begin
			case (opcode)
				OP_RTYPE, OP_ITYPE: begin
					case (funct3)
						3'b000: aluOp = (opcode == OP_RTYPE && ir[30]) ? ALU_SUB : ALU_ADD;
						3'b010: aluOp = ALU_SLT;
						3'b100: aluOp = ALU_XOR;
						3'b110: aluOp = ALU_OR;
						3'b111: aluOp = ALU_AND;
						default: aluOp = ALU_ADD;
					endcase
				end
				OP_BRANCH: aluOp = ALU_SUB;
				default: aluOp = ALU_ADD;
			endcase
		end
	end

	assign aluA = aSel ? regA : pc;
	assign aluB = bSel ? regB : imm;
	assign branchTaken = funct3[0] ? ~aluZero : aluZero; // bne : beq

	assign rfRaddr1 = ir[19:15];
	assign rfRaddr2 = ir[24:20];
	assign rfWaddr = ir[11:7];

	always_comb begin
		case (wbSel)
			WBSEL_LOAD: rfWdata = memRdata;
			WBSEL_LINK: rfWdata = pcPlus4; // pc not yet updated
			default: rfWdata = aluOut;
		endcase
	end

	assign memAddr = aluOut;
	assign memWdata = regB;

endmodule

// File: program_golden.mem
// Header: program words, data words, store count, final retired count
// Then program, initial data memory, and expected (paddr, pwdata) store pairs
0000002C 00000020 00000010 00000025
00002083 00402103 002081B3 00302823 40208233 00402A23 0020F2B3 0020E333
0020C3B3 00112433 00502C23 00602E23 02702023 02802223 FFF08493 0FF17513
7000E593 FFF0C613 FEC12693 02902423 02A02623 02B02823 02C02A23 02D02C23
00802703 00870713 02E02E23 00108463 04102023 00208463 04302023 00209463
04102223 00109463 04402223 00C007EF 04102423 04102423 04F02423 01878867
04102623 04102623 05002623 0000006F
00000011 FFFFFFF0 12345678 00000007 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000010 00000001 00000014 00000021 00000018 00000010 0000001C FFFFFFF1
00000020 FFFFFFE1 00000024 00000001 00000028 00000010 0000002C 000000F0
00000030 00000711 00000034 FFFFFFEE 00000038 00000000 0000003C 12345680
00000040 00000001 00000044 00000021 00000048 00000090 0000004C 000000A0

// File: regFile.sv
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
	input logic CLK,
	input regIdx_t raddr1,
	input regIdx_t raddr2,
	input regIdx_t waddr,
	input word_t wdata,
	input logic we,
	output word_t rdata1,
	output word_t rdata2
);

	word_t regs [0:31];

	always_ff @(posedge CLK) begin
		if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

	// x0 reads as zero, entry 0 never written
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: run.sh
#!/bin/sh
# Builds the cpuTb simulation with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f build.f --top-module cpuTb -o cpuTbSim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/cpuTbSim; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0

// File: tbClock.sv
`timescale 1ns/1ns

module tbClock #(
	parameter int PERIOD = 10
) (
	output logic CLK
);

	initial CLK = 1'b0;

	always #(PERIOD / 2) CLK = ~CLK;

endmodule
